// File: common/ma_pkg.sv
`default_nettype none

package ma_pkg;

    localparam int unsigned xlen = 32;          // Data and address width
    localparam int unsigned jump_bit = 2;       // Function bit that marks a jump in the BRU

    typedef logic [4:0] rf_add_t;               // Destination register address
    typedef logic [2:0] f_part_t;               // Instruction function code

    // Load function codes taken from RISC-V funct3
    localparam f_part_t LD_B  = 3'b000;         // Signed byte
    localparam f_part_t LD_H  = 3'b001;         // Signed halfword
    localparam f_part_t LD_W  = 3'b010;         // Word
    localparam f_part_t LD_BU = 3'b100;         // Unsigned byte
    localparam f_part_t LD_HU = 3'b101;         // Unsigned halfword

    // Instruction kind flags
    // An all-zero value marks an empty slot
    typedef struct packed {
        logic [1:0] rsvd;                       // Spare, kept zero by EX
        logic       lsu;                        // Load or store
        logic       bru;                        // Branch or jump
        logic       alu;                        // Arithmetic result
        logic       csr;                        // CSR access
        logic       rvc;                        // Compressed encoding
        logic       reg_dest;                   // Writes the register file
    } ictrl_t;

    // Value word coming from EX
    // Branch targets are halfword aligned so bit 0 carries the condition
    typedef union packed {
        logic [xlen-1:0] plain;                 // Result or memory address
        struct packed {
            logic [xlen-2:0] tadd;              // Target address bits 31..1
            logic            cond;              // Branch condition fulfilled
        } br;
    } ex_value_u;

    // EX to MA instruction
    typedef struct packed {
        ictrl_t    ictrl;                       // Instruction kind
        f_part_t   funct;                       // Function code
        rf_add_t   rd;                          // Destination register
        ex_value_u val;                         // EX value
        logic      predicted;                   // Taken predicted at fetch
    } ma_instr_t;

    // Load formatting info carried to WB
    typedef struct packed {
        f_part_t    funct;                      // Size and sign
        logic [1:0] offset;                     // Byte offset in the word
    } ld_info_t;

    // Register file write port from WB
    typedef struct packed {
        logic            we;                    // Write enable
        rf_add_t         rd;                    // Target register
        logic [xlen-1:0] val;                   // Formatted value
    } wb_out_t;

endpackage

`default_nettype wire

// File: rtl/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolver import ma_pkg::*; (
    input  ma_instr_t       instr_i,            // Instruction in MA
    input  logic [xlen-2:0] bop_tadd_i,         // Target predicted at fetch
    input  logic [xlen-1:0] next_pc_i,          // Sequential address
    output logic            toc_o,              // Misprediction, redirect fetch
    output logic            taken_o,            // Resolved as taken
    output logic [xlen-1:0] target_o            // Address the PC should follow
);

    logic            is_bru;                    // Branch or jump present
    logic            is_jump;
    logic            outcome;                   // Taken outcome before gating
    logic            dir_miss;                  // Direction differs from prediction
    logic            tadd_miss;                 // Same direction but other target
    logic [xlen-1:0] br_target;

    assign is_bru  = instr_i.ictrl.bru;
    assign is_jump = instr_i.funct[jump_bit];   // Top function bit selects a jump

    // Jumps always go, branches follow the EX condition bit
    assign outcome = is_jump | instr_i.val.br.cond;
    assign taken_o = is_bru & outcome;

    // Target sits above the condition bit
    assign br_target = {instr_i.val.br.tadd, 1'b0};

    always_comb begin
        dir_miss  = outcome != instr_i.predicted;
        tadd_miss = outcome & instr_i.predicted
                  & (instr_i.val.br.tadd != bop_tadd_i);  // Fetch went to wrong place
        toc_o     = is_bru & (dir_miss | tadd_miss);
    end

    // Not taken resolves to the fall-through address
    // which fetch has to return to after a wrong taken guess
    assign target_o = taken_o ? br_target : next_pc_i;

endmodule

`default_nettype wire

// File: rtl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit import ma_pkg::*; (
    input  logic            s_clk_i,            // Clock
    input  logic            rst_n_i,            // Async reset, active low
    input  logic [xlen-1:0] s_boot_add_i,       // Reset value of the PC
    input  ma_instr_t       instr_i,            // Instruction in MA
    input  logic            lsu_ready_i,        // LSU ready
    input  logic            toc_i,              // Misprediction from resolver
    input  logic            taken_i,            // Branch or jump taken
    input  logic [xlen-1:0] target_i,           // Resolved address
    output logic [xlen-1:0] pc_o,               // Current PC
    output logic [xlen-1:0] next_pc_o,          // Sequential address
    output logic [xlen-1:0] toc_addr_o,         // Redirect address
    output logic            stall_o,            // LSU transfer extended
    output logic            flush_o             // Flush lower stages
);

    logic [xlen-1:0] pc_q;                      // PC of the instruction in MA
    logic [xlen-1:0] pc_incr;                   // Instruction size in bytes
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] new_pc;                    // Address after this instruction
    logic            slot_empty;
    logic            pc_we;

    assign slot_empty = instr_i.ictrl == '0;    // No instruction this cycle

    // Stall while a data transfer waits on the bus
    assign stall_o = instr_i.ictrl.lsu & ~lsu_ready_i;

    // Compressed instructions are two bytes long
    assign pc_incr = instr_i.ictrl.rvc ? xlen'(2) : xlen'(4);
    assign next_pc = pc_q + pc_incr;

    // Taken transfer follows the resolved target
    assign new_pc = taken_i ? target_i : next_pc;

    // Advance only when an instruction retires from MA
    assign pc_we = ~slot_empty & ~stall_o;

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= s_boot_add_i;               // Start at boot address
        end else if (pc_we) begin
            pc_q <= new_pc;
        end
    end

    assign pc_o       = pc_q;
    assign next_pc_o  = next_pc;                // Also the link value
    assign toc_addr_o = new_pc;
    assign flush_o    = toc_i;                  // Only mispredictions redirect here

endmodule

`default_nettype wire

// File: rtl/mawb_register.sv
`timescale 1ns/1ps
`default_nettype none

module mawb_register import ma_pkg::*; (
    input  logic            s_clk_i,            // Clock
    input  logic            rst_n_i,            // Async reset, active low
    input  ma_instr_t       instr_i,            // Instruction in MA
    input  logic            stall_i,            // LSU transfer extended
    input  logic [xlen-1:0] next_pc_i,          // Link value for jumps
    input  logic [xlen-1:0] lsu_data_i,         // LSU read data
    output rf_add_t         rd_o,               // Destination in WB
    output logic            we_o,               // Register file write in WB
    output logic            lsu_o,              // WB holds a load or store
    output logic [xlen-1:0] raw_val_o,          // Unformatted result
    output ld_info_t        ld_info_o           // Load size, sign and offset
);

    logic            slot_valid;                // Instruction leaves MA this cycle
    logic [xlen-1:0] result;                    // Stage result
    ld_info_t        ldi;

    logic            we_q;
    logic            lsu_q;
    rf_add_t         rd_q;
    logic [xlen-1:0] val_q;
    ld_info_t        ldi_q;

    // A stalled slot turns into a bubble in WB
    assign slot_valid = (instr_i.ictrl != '0) & ~stall_i;

    // Stage result selection
    always_comb begin
        if (instr_i.ictrl.lsu) begin
            result = lsu_data_i;                // Raw bus word
        end else if (instr_i.ictrl.bru) begin
            result = next_pc_i;                 // Link address
        end else begin
            result = instr_i.val.plain;
        end
    end

    // Low address bits pick the byte lane later in WB
    assign ldi = '{funct: instr_i.funct, offset: instr_i.val.plain[1:0]};

    // Control part
    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_q  <= 1'b0;
            lsu_q <= 1'b0;
        end else begin
            we_q  <= slot_valid & instr_i.ictrl.reg_dest;
            lsu_q <= slot_valid & instr_i.ictrl.lsu;
        end
    end

    // Payload part, only loaded by a real instruction
    always_ff @(posedge s_clk_i) begin
        if (slot_valid) begin
            rd_q  <= instr_i.rd;
            val_q <= result;
            ldi_q <= ldi;
        end
    end

    assign rd_o      = rd_q;
    assign we_o      = we_q;
    assign lsu_o     = lsu_q;
    assign raw_val_o = val_q;
    assign ld_info_o = ldi_q;

endmodule

`default_nettype wire

// File: rtl/load_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module load_decoder import ma_pkg::*; (
    input  logic [xlen-1:0] raw_val_i,          // Word from the MA/WB register
    input  ld_info_t        ld_info_i,          // Size, sign and offset
    input  logic            lsu_i,              // Value came from the LSU
    output logic [xlen-1:0] val_o               // Formatted value
);

    logic [7:0]  sel_byte;                      // Addressed byte lane
    logic [15:0] sel_half;                      // Addressed halfword

    // Byte lane from both offset bits, halfword from the upper one
    assign sel_byte = raw_val_i[{ld_info_i.offset, 3'b000} +: 8];
    assign sel_half = raw_val_i[{ld_info_i.offset[1], 4'b0000} +: 16];

    always_comb begin
        val_o = raw_val_i;                      // Words and non-loads pass
        if (lsu_i) begin
            case (ld_info_i.funct)
                LD_B: begin
                    val_o = {{(xlen-8){sel_byte[7]}}, sel_byte};
                end
                LD_BU: begin
                    val_o = {{(xlen-8){1'b0}}, sel_byte};
                end
                LD_H: begin
                    val_o = {{(xlen-16){sel_half[15]}}, sel_half};
                end
                LD_HU: begin
                    val_o = {{(xlen-16){1'b0}}, sel_half};
                end
                LD_W: begin
                    val_o = raw_val_i;
                end
                default: begin
                    // Store codes and others keep the raw word
                    val_o = raw_val_i;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/ma_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ma_stage import ma_pkg::*; (
    input  logic            s_clk_i,            // Clock
    input  logic            rst_n_i,            // Async reset, active low
    input  logic [xlen-1:0] s_boot_add_i,       // Boot address
    input  ma_instr_t       exma_i,             // Instruction from EX
    input  logic [xlen-2:0] bop_tadd_i,         // Predicted target from fetch
    input  logic [xlen-1:0] lsu_data_i,         // LSU read data
    input  logic            lsu_ready_i,        // LSU ready
    output logic            stall_o,            // Stall for lower stages
    output logic            flush_o,            // Flush for lower stages
    output logic [xlen-1:0] toc_addr_o,         // Redirect address
    output logic [xlen-1:0] pc_o,               // Program counter
    output wb_out_t         wb_o                // Register file write
);

    logic            toc;                       // Transfer of control needed
    logic            taken;                     // Branch or jump taken
    logic [xlen-1:0] target;                    // Resolved address
    logic [xlen-1:0] next_pc;                   // Sequential address
    logic            stall;                     // LSU transfer extended
    rf_add_t         mawb_rd;
    logic            mawb_we;
    logic            mawb_lsu;
    logic [xlen-1:0] mawb_raw_val;              // Unformatted result in WB
    ld_info_t        mawb_ldi;
    logic [xlen-1:0] wb_val;                    // Formatted result in WB

    // Branch and jump outcome
    branch_resolver u_branch_resolver (
        .instr_i    (exma_i),
        .bop_tadd_i (bop_tadd_i),
        .next_pc_i  (next_pc),
        .toc_o      (toc),
        .taken_o    (taken),
        .target_o   (target)
    );

    // Program counter and redirect
    pc_unit u_pc_unit (
        .s_clk_i      (s_clk_i),
        .rst_n_i      (rst_n_i),
        .s_boot_add_i (s_boot_add_i),
        .instr_i      (exma_i),
        .lsu_ready_i  (lsu_ready_i),
        .toc_i        (toc),
        .taken_i      (taken),
        .target_i     (target),
        .pc_o         (pc_o),
        .next_pc_o    (next_pc),
        .toc_addr_o   (toc_addr_o),
        .stall_o      (stall),
        .flush_o      (flush_o)
    );

    // MA/WB pipeline register
    mawb_register u_mawb_register (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .instr_i    (exma_i),
        .stall_i    (stall),
        .next_pc_i  (next_pc),
        .lsu_data_i (lsu_data_i),
        .rd_o       (mawb_rd),
        .we_o       (mawb_we),
        .lsu_o      (mawb_lsu),
        .raw_val_o  (mawb_raw_val),
        .ld_info_o  (mawb_ldi)
    );

    // WB load formatting
    load_decoder u_load_decoder (
        .raw_val_i (mawb_raw_val),
        .ld_info_i (mawb_ldi),
        .lsu_i     (mawb_lsu),
        .val_o     (wb_val)
    );

    assign stall_o = stall;
    assign wb_o    = '{we: mawb_we, rd: mawb_rd, val: wb_val};

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,                         // Testbench clock
    output logic rst_n_o                        // Reset, active low
);

    localparam int half_period = 5;             // 10 ns clock
    localparam int reset_cycles = 2;

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    // Reset spans two rising edges and lets go on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/ma_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ma_stage_sva import ma_pkg::*; (
    input logic            s_clk_i,             // DUT clock
    input logic            rst_n_i,             // DUT reset
    input logic            stall_i,             // DUT stall_o
    input logic            flush_i,             // DUT flush_o
    input logic [xlen-1:0] pc_i,                // DUT pc_o
    input wb_out_t         wb_i,                // DUT wb_o
    input ma_instr_t       exma_i               // Instruction in MA
);

    // PC must not move while the LSU holds the stage
    pc_holds_on_stall: assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(pc_i)
    ) else $error("pc_o changed across a stalled cycle");

    // A stalled slot reaches WB as a bubble
    no_write_after_stall: assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        stall_i |=> !wb_i.we
    ) else $error("wb_o.we set in the cycle after a stall");

    // Empty slots never redirect fetch
    no_flush_on_empty: assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        (exma_i.ictrl == '0) |-> !flush_i
    ) else $error("flush_o raised on an empty slot");

endmodule

bind ma_stage ma_stage_sva u_sva (
    .s_clk_i (s_clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_o),
    .flush_i (flush_o),
    .pc_i    (pc_o),
    .wb_i    (wb_o),
    .exma_i  (exma_i)
);

`default_nettype wire

// File: test/tb_ma_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ma_stage import ma_pkg::*; ();

    localparam logic [xlen-1:0] boot_add = 32'h0000_1000;  // PC after reset
    localparam int cycles_per_case = 40;                    // Watchdog budget per case

    // One line of the case file
    typedef struct packed {
        ictrl_t      ictrl;
        f_part_t     funct;
        rf_add_t     rd;
        logic [31:0] val;                       // EX value, plain view
        logic        predicted;
        logic [30:0] bop_tadd;
        logic [31:0] lsu_data;
        logic [31:0] ready_max;                 // Longest random stall or 0 for none
        logic        exp_toc;
        logic [31:0] exp_addr;                  // Redirect address when exp_toc
        logic [31:0] exp_wb;                    // WB value when rd is written
        logic [31:0] exp_delta;                 // PC change after the case
    } case_t;

    logic            clk;
    logic            rst_n;
    ma_instr_t       exma;
    logic [xlen-2:0] bop_tadd;
    logic [xlen-1:0] lsu_data;
    logic            lsu_ready;
    logic            stall;
    logic            flush;
    logic [xlen-1:0] toc_addr;
    logic [xlen-1:0] pc;
    wb_out_t         wb;

    case_t           cases[$];
    int              stall_lens[$];             // Drawn stall per case
    int              stall_sum;
    int              errors;
    int              cur_case;                  // 0 is the reset check
    integer          seed;
    logic [xlen-1:0] exp_pc;                    // Reference PC
    bit              cases_loaded;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ma_stage u_dut (
        .s_clk_i      (clk),
        .rst_n_i      (rst_n),
        .s_boot_add_i (boot_add),
        .exma_i       (exma),
        .bop_tadd_i   (bop_tadd),
        .lsu_data_i   (lsu_data),
        .lsu_ready_i  (lsu_ready),
        .stall_o      (stall),
        .flush_o      (flush),
        .toc_addr_o   (toc_addr),
        .pc_o         (pc),
        .wb_o         (wb)
    );

    task automatic check_value(
        input string       what,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns, case %0d: %s is %h, expected %h",
                     $time, cur_case, what, actual, expected);
        end
    endtask

    // Reads the case file and draws a stall length for each line
    task automatic load_cases(output bit ok);
        int          fd;
        int          count;
        int          stall_len;
        string       line;
        case_t       c;
        logic [31:0] f_ictrl;
        logic [31:0] f_funct;
        logic [31:0] f_rd;
        logic [31:0] f_val;
        logic [31:0] f_pred;
        logic [31:0] f_bop;
        logic [31:0] f_data;
        logic [31:0] f_ready;
        logic [31:0] f_toc;
        logic [31:0] f_addr;
        logic [31:0] f_wb;
        logic [31:0] f_delta;
        ok = 1'b0;
        fd = $fopen("test/ma_cases.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;                   // Blank or column notes
                end
                count = $sscanf(line, "%h %h %h %h %h %h %h %d %h %h %h %h",
                                f_ictrl, f_funct, f_rd, f_val, f_pred, f_bop,
                                f_data, f_ready, f_toc, f_addr, f_wb, f_delta);
                if (count != 12) begin
                    errors++;
                    $display("Malformed line in the case file: %s", line);
                end else begin
                    c.ictrl     = ictrl_t'(f_ictrl[7:0]);
                    c.funct     = f_funct[2:0];
                    c.rd        = f_rd[4:0];
                    c.val       = f_val;
                    c.predicted = f_pred[0];
                    c.bop_tadd  = f_bop[30:0];
                    c.lsu_data  = f_data;
                    c.ready_max = f_ready;
                    c.exp_toc   = f_toc[0];
                    c.exp_addr  = f_addr;
                    c.exp_wb    = f_wb;
                    c.exp_delta = f_delta;
                    cases.push_back(c);
                    // Between 1 and ready_max cycles of ready low
                    stall_len = (c.ready_max == 0) ? 0
                              : int'(($unsigned($random(seed)) % c.ready_max) + 1);
                    stall_lens.push_back(stall_len);
                    stall_sum += stall_len;
                end
            end
            $fclose(fd);
        end
    endtask

    // Starts and ends on a falling edge
    task automatic run_case(input int idx);
        case_t c;
        int    stall_len;
        int    k;
        logic  exp_we;
        c         = cases[idx];
        stall_len = stall_lens[idx];
        exp_we    = c.ictrl.reg_dest;           // Empty slots have it clear
        exma.ictrl     = c.ictrl;
        exma.funct     = c.funct;
        exma.rd        = c.rd;
        exma.val.plain = c.val;
        exma.predicted = c.predicted;
        bop_tadd       = c.bop_tadd;
        lsu_data       = c.lsu_data;
        lsu_ready      = stall_len == 0;
        #1;
        check_value("flush_o", 32'(flush), 32'(c.exp_toc));
        if (c.exp_toc) begin
            check_value("toc_addr_o", toc_addr, c.exp_addr);
        end
        for (k = 0; k < stall_len; k++) begin
            check_value("stall_o", 32'(stall), 32'd1);
            @(negedge clk);
            check_value("pc_o during stall", pc, exp_pc);
            check_value("wb_o.we during stall", 32'(wb.we), 32'd0);
        end
        if (stall_len > 0) begin
            lsu_ready = 1'b1;                   // Bus answers on this edge
            #1;
        end
        check_value("stall_o", 32'(stall), 32'd0);
        @(negedge clk);
        exp_pc = exp_pc + c.exp_delta;
        check_value("pc_o", pc, exp_pc);
        check_value("wb_o.we", 32'(wb.we), 32'(exp_we));
        if (exp_we) begin
            check_value("wb_o.rd", 32'(wb.rd), 32'(c.rd));
            check_value("wb_o.val", wb.val, c.exp_wb);
        end
    endtask

    initial begin : stimulus
        bit ok;
        exma         = '0;
        bop_tadd     = '0;
        lsu_data     = '0;
        lsu_ready    = 1'b1;
        errors       = 0;
        stall_sum    = 0;
        cur_case     = 0;
        seed         = 32'h8d4b6533;
        exp_pc       = boot_add;
        cases_loaded = 1'b0;
        load_cases(ok);
        if (!ok) begin
            $display("Could not open the case file test/ma_cases.txt");
            $display("Errors found");
            $finish;
        end else begin
            cases_loaded = 1'b1;                // Arms the watchdog
            @(posedge rst_n);
            @(negedge clk);
            check_value("pc_o after reset", pc, boot_add);
            check_value("wb_o.we after reset", 32'(wb.we), 32'd0);
            foreach (cases[i]) begin
                cur_case = i + 1;
                run_case(i);
            end
            $display("Finished %0d cases with %0d errors", cases.size(), errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int limit;
        wait (cases_loaded);
        limit = cases.size() * cycles_per_case + stall_sum;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/ma_cases.txt
# ictrl funct rd val predicted bop_tadd lsu_data ready_max(dec, 0 means ready at once)
# exp_toc exp_toc_addr exp_wb_val exp_pc_delta, all other columns hex
00 0 00 00000000 0 00000000 00000000 0 0 00000000 00000000 00000000
00 0 00 00000000 0 00000000 00000000 0 0 00000000 00000000 00000000
09 0 05 deadbeef 0 00000000 00000000 0 0 00000000 deadbeef 00000004
0b 0 06 12345678 0 00000000 00000000 0 0 00000000 12345678 00000002
08 0 07 0000abcd 0 00000000 00000000 0 0 00000000 00000000 00000004
10 0 00 00001101 0 00000000 00000000 0 1 00001100 00000000 000000f6
10 1 00 00001200 1 00000900 00000000 0 1 00001104 00000000 00000004
10 0 00 00001181 1 000008c0 00000000 0 0 00000000 00000000 0000007c
10 1 00 00002000 0 00000000 00000000 0 0 00000000 00000000 00000004
10 0 00 00001201 1 00000904 00000000 0 1 00001200 00000000 0000007c
11 4 01 00001403 0 00000000 00000000 0 1 00001402 00001204 00000202
13 4 01 00001500 1 00000a80 00000000 0 0 00000000 00001404 000000fe
21 0 0a 00002000 0 00000000 f1827364 0 0 00000000 00000064 00000004
21 0 0a 00002001 0 00000000 f1827364 0 0 00000000 00000073 00000004
21 0 0a 00002002 0 00000000 f1827364 0 0 00000000 ffffff82 00000004
21 0 0a 00002003 0 00000000 f1827364 0 0 00000000 fffffff1 00000004
21 4 0b 00002002 0 00000000 f1827364 0 0 00000000 00000082 00000004
21 4 0b 00002003 0 00000000 f1827364 0 0 00000000 000000f1 00000004
21 1 0c 00002000 0 00000000 f1827364 0 0 00000000 00007364 00000004
21 1 0c 00002002 0 00000000 f1827364 0 0 00000000 fffff182 00000004
21 5 0d 00002002 0 00000000 f1827364 0 0 00000000 0000f182 00000004
21 5 0d 00002000 0 00000000 f1827364 0 0 00000000 00007364 00000004
21 2 0e 00002004 0 00000000 f1827364 0 0 00000000 f1827364 00000004
21 0 0f 00002000 0 00000000 00000080 0 0 00000000 ffffff80 00000004
21 1 10 00002000 0 00000000 00008001 5 0 00000000 ffff8001 00000004
21 4 11 00002001 0 00000000 0000ab00 8 0 00000000 000000ab 00000004
21 2 12 00002004 0 00000000 0badf00d 3 0 00000000 0badf00d 00000004
00 0 00 00000000 0 00000000 00000000 0 0 00000000 00000000 00000000
0b 0 1f 00000000 0 00000000 00000000 0 0 00000000 00000000 00000002
00 0 00 00000000 0 00000000 00000000 0 0 00000000 00000000 00000000

// File: vlog.f
common/ma_pkg.sv
rtl/branch_resolver.sv
rtl/pc_unit.sv
rtl/mawb_register.sv
rtl/load_decoder.sv
rtl/ma_stage.sv
test/tb_clock_gen.sv
test/ma_stage_sva.sv
test/tb_ma_stage.sv

// File: run.sh
#!/usr/bin/env bash
# Build the MA stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ma_stage -f vlog.f -o tb_ma_stage \
    && ./obj_dir/tb_ma_stage | tee /dev/stderr | grep -x "No errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
